// ==== memPkg.sv ====
package memPkg;

    // 4096-byte RAM, upper address bits are dropped
    localparam int RamAddrBits = 12;

    typedef logic [15:0] memAddr;
    typedef logic [7:0]  memByte;
    typedef logic [31:0] memWord;

    // value is the byte count of the access
    typedef enum logic [2:0] {
        LenByte = 3'd1,
        LenHalf = 3'd2,
        LenWord = 3'd4
    } xferLen;

    typedef enum logic [1:0] {
        Idle,
        Fetch,
        Load,
        Store
    } ctrlState;

    typedef enum logic [1:0] {
        EvNone,
        EvFetch,
        EvLoad,
        EvStore
    } txnEvent;

    typedef struct packed {
        logic   valid;
        memAddr addr;
    } fetchReq;

    typedef struct packed {
        logic   done;
        memWord inst;
    } fetchResp;

    typedef struct packed {
        logic   valid;
        logic   write;
        xferLen len;
        memAddr addr;
        memWord wdata;
    } dataReq;

    typedef struct packed {
        logic   done;
        memWord rdata;
    } dataResp;

    typedef struct packed {
        logic                   we;
        logic [RamAddrBits-1:0] addr;
        memByte                 wdata;
    } ramPort;

endpackage

// ==== regPkg.sv ====
package regPkg;

    localparam int CntBits = 16;

    typedef logic [7:0]  regAddr;
    typedef logic [31:0] regData;

    // register map
    localparam regAddr OffCtrl     = 8'h00;
    localparam regAddr OffFetchCnt = 8'h04;
    localparam regAddr OffLoadCnt  = 8'h08;
    localparam regAddr OffStoreCnt = 8'h0C;

    typedef struct packed {
        logic   psel;
        logic   penable;
        logic   pwrite;
        regAddr paddr;
        regData pwdata;
    } apbReq;

    typedef struct packed {
        logic   pready;
        regData prdata;
        logic   pslverr;
    } apbResp;

    // bit 0 and bit 1 of the control register
    typedef struct packed {
        logic fetchFirst;
        logic pause;
    } ctrlBits;

endpackage

// ==== byteRam.sv ====
`timescale 1ns/1ps

module byteRam (
    input  logic           clk,
    input  memPkg::ramPort port,
    output memPkg::memByte readData
);

    memPkg::memByte mem [2**memPkg::RamAddrBits];

    // write port
    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.addr] <= port.wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        readData <= mem[port.addr];
    end

endmodule

// ==== memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  memPkg::fetchReq   fetchIn,
    output memPkg::fetchResp  fetchOut,
    input  memPkg::dataReq    dataIn,
    output memPkg::dataResp   dataOut,
    input  regPkg::ctrlBits   ctrl,
    output memPkg::ramPort    ram,
    input  memPkg::memByte    ramData,
    output memPkg::txnEvent   ctrlEvent
);

    memPkg::ctrlState state;
    memPkg::memAddr   base;
    memPkg::xferLen   len;
    memPkg::memWord   storeWord;
    memPkg::memWord   asmWord;
    memPkg::memWord   rdWord;
    memPkg::memAddr   byteAddr;
    logic [2:0]       stage;
    logic             rdValid;
    logic [1:0]       rdIdx;
    logic             isRead;
    logic             issue;
    logic             done;
    logic             pickData;
    logic             pickFetch;
    logic             ramWe;
    logic [memPkg::RamAddrBits-1:0] ramAddr;
    memPkg::memByte   ramWdata;

    assign isRead   = (state == memPkg::Fetch) || (state == memPkg::Load);
    assign issue    = (state != memPkg::Idle) && (stage < len);
    assign byteAddr = base + memPkg::memAddr'(stage);

    // data port wins a tie unless fetchFirst is set
    assign pickData  = dataIn.valid && !(fetchIn.valid && ctrl.fetchFirst);
    assign pickFetch = fetchIn.valid && !pickData;

    // reads finish one cycle after the last byte address, stores right after the last write
    always_comb begin
        if (isRead) begin
            done = !ctrl.pause && (stage == len + 3'd1);
        end else if (state == memPkg::Store) begin
            done = !ctrl.pause && (stage == len);
        end else begin
            done = 1'b0;
        end
    end

    // last byte comes straight from the ram in the done cycle
    always_comb begin
        rdWord = asmWord;
        if (rdValid) begin
            rdWord[rdIdx*8 +: 8] = ramData;
        end
    end

    always_comb begin
        fetchOut.done  = done && (state == memPkg::Fetch);
        fetchOut.inst  = rdWord;
        dataOut.done   = done && (state != memPkg::Fetch);
        dataOut.rdata  = rdWord;
    end

    always_comb begin
        ctrlEvent = memPkg::EvNone;
        if (done) begin
            case (state)
                memPkg::Fetch: ctrlEvent = memPkg::EvFetch;
                memPkg::Load:  ctrlEvent = memPkg::EvLoad;
                memPkg::Store: ctrlEvent = memPkg::EvStore;
                default:       ctrlEvent = memPkg::EvNone;
            endcase
        end
    end

    assign ram = '{we: ramWe, addr: ramAddr, wdata: ramWdata};

    // state, stage counter and write enable
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::Idle;
            stage <= '0;
            ramWe <= 1'b0;
        end else if (ctrl.pause) begin
            ramWe <= 1'b0;
        end else begin
            ramWe <= 1'b0;
            case (state)
                memPkg::Idle: begin
                    stage <= '0;
                    if (pickData) begin
                        state <= dataIn.write ? memPkg::Store : memPkg::Load;
                    end else if (pickFetch) begin
                        state <= memPkg::Fetch;
                    end
                end
                default: begin
                    if (done) begin
                        state <= memPkg::Idle;
                    end else if (issue) begin
                        ramWe <= (state == memPkg::Store);
                        stage <= stage + 3'd1;
                    end else begin
                        // waiting for the last read byte
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // latched request and ram address/data
    always_ff @(posedge clk) begin
        if (!ctrl.pause) begin
            if (state == memPkg::Idle) begin
                if (pickData) begin
                    base      <= dataIn.addr;
                    len       <= dataIn.len;
                    storeWord <= dataIn.wdata;
                end else if (pickFetch) begin
                    base <= fetchIn.addr;
                    len  <= memPkg::LenWord;
                end
            end else if (issue) begin
                ramAddr  <= byteAddr[memPkg::RamAddrBits-1:0];
                ramWdata <= storeWord[stage*8 +: 8];
            end
        end
    end

    // the ram reads every cycle, even while paused, so the byte
    // tracker and the assembly word follow it rather than the FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= isRead && (stage != 3'd0) && (stage <= len);
        end
    end

    always_ff @(posedge clk) begin
        rdIdx <= 2'(stage - 3'd1);
        // cleared while idle so short loads come out zero-extended
        if (state == memPkg::Idle) begin
            asmWord <= '0;
        end else begin
            asmWord <= rdWord;
        end
    end

endmodule

// ==== memRegs.sv ====
`timescale 1ns/1ps

module memRegs (
    input  logic            clk,
    input  logic            rst,
    input  regPkg::apbReq   apbIn,
    output regPkg::apbResp  apbOut,
    input  memPkg::txnEvent ctrlEvent,
    output regPkg::ctrlBits ctrl
);

    // 0 fetch, 1 load, 2 store
    logic [regPkg::CntBits-1:0] cnt [3];
    logic [2:0]     hit;
    logic           access;
    logic           mapped;
    logic           isCnt;
    logic           clearCnt;
    regPkg::regData rdData;

    assign access = apbIn.psel && apbIn.penable;

    assign isCnt = (apbIn.paddr == regPkg::OffFetchCnt)
                || (apbIn.paddr == regPkg::OffLoadCnt)
                || (apbIn.paddr == regPkg::OffStoreCnt);

    assign clearCnt = access && apbIn.pwrite && isCnt;

    assign hit[0] = (ctrlEvent == memPkg::EvFetch);
    assign hit[1] = (ctrlEvent == memPkg::EvLoad);
    assign hit[2] = (ctrlEvent == memPkg::EvStore);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (access && apbIn.pwrite && (apbIn.paddr == regPkg::OffCtrl)) begin
            ctrl.fetchFirst <= apbIn.pwdata[0];
            ctrl.pause      <= apbIn.pwdata[1];
        end
    end

    // saturating counters, a clear beats a same-cycle increment
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else if (clearCnt) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (hit[i] && (cnt[i] != '1)) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // read mux
    always_comb begin
        rdData = '0;
        mapped = 1'b1;
        case (apbIn.paddr)
            regPkg::OffCtrl: begin
                rdData[0] = ctrl.fetchFirst;
                rdData[1] = ctrl.pause;
            end
            regPkg::OffFetchCnt: rdData = regPkg::regData'(cnt[0]);
            regPkg::OffLoadCnt:  rdData = regPkg::regData'(cnt[1]);
            regPkg::OffStoreCnt: rdData = regPkg::regData'(cnt[2]);
            default:             mapped = 1'b0;
        endcase
    end

    // zero wait states
    always_comb begin
        apbOut.pready  = 1'b1;
        apbOut.prdata  = rdData;
        apbOut.pslverr = access && !mapped;
    end

endmodule

// ==== memSubsys.sv ====
`timescale 1ns/1ps

module memSubsys (
    input  logic             clk,
    input  logic             rst,
    input  memPkg::fetchReq  fetchIn,
    output memPkg::fetchResp fetchOut,
    input  memPkg::dataReq   dataIn,
    output memPkg::dataResp  dataOut,
    input  regPkg::apbReq    apbIn,
    output regPkg::apbResp   apbOut
);

    memPkg::ramPort  ramReq;
    memPkg::memByte  ramData;
    memPkg::txnEvent ctrlEvent;
    regPkg::ctrlBits ctrl;

    memCtrl uCtrl (
        .clk       (clk),
        .rst       (rst),
        .fetchIn   (fetchIn),
        .fetchOut  (fetchOut),
        .dataIn    (dataIn),
        .dataOut   (dataOut),
        .ctrl      (ctrl),
        .ram       (ramReq),
        .ramData   (ramData),
        .ctrlEvent (ctrlEvent)
    );

    byteRam uRam (
        .clk      (clk),
        .port     (ramReq),
        .readData (ramData)
    );

    // control bits and counters on APB
    memRegs uRegs (
        .clk       (clk),
        .rst       (rst),
        .apbIn     (apbIn),
        .apbOut    (apbOut),
        .ctrlEvent (ctrlEvent),
        .ctrl      (ctrl)
    );

endmodule

// ==== tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker (
    input  logic             clk,
    input  logic             rst,
    input  memPkg::fetchReq  fetchIn,
    input  memPkg::fetchResp fetchOut,
    input  memPkg::dataReq   dataIn,
    input  memPkg::dataResp  dataOut,
    input  regPkg::apbReq    apbIn,
    input  regPkg::apbResp   apbOut,
    output int               errors,
    output int               checks
);

    memPkg::memByte model [2**memPkg::RamAddrBits];

    // in-flight transaction with a fetch held as a 4-byte load
    logic           busy;
    logic           curFetch;
    memPkg::dataReq cur;
    int             lat;
    logic           stalled;

    logic fetchFirst;
    logic pause;
    int   cntFetch;
    int   cntLoad;
    int   cntStore;

    function automatic memPkg::memWord modelWord(memPkg::memAddr a, int n);
        memPkg::memWord w;
        memPkg::memAddr idx;
        w = '0;
        for (int i = 0; i < n; i++) begin
            idx = a + memPkg::memAddr'(i);
            w[i*8 +: 8] = model[idx[memPkg::RamAddrBits-1:0]];
        end
        return w;
    endfunction

    task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic fault(string what);
        errors++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic acceptReq();
        busy = 1'b1;
        lat = 0;
        stalled = 1'b0;
        // a tie goes to the fetch port only when fetchFirst is set
        if (dataIn.valid && fetchIn.valid) begin
            curFetch = fetchFirst;
        end else begin
            curFetch = fetchIn.valid;
        end
        if (curFetch) begin
            cur = '{valid: 1'b1, write: 1'b0, len: memPkg::LenWord,
                    addr: fetchIn.addr, wdata: '0};
        end else begin
            cur = dataIn;
        end
    endtask

    task automatic finishTxn();
        int n;
        memPkg::memAddr idx;
        n = int'(cur.len);
        if (curFetch) begin
            if (!stalled) compare("fetch latency", n + 2, lat);
            compare("fetch inst", modelWord(cur.addr, 4), fetchOut.inst);
            cntFetch++;
        end else if (cur.write) begin
            if (!stalled) compare("store latency", n + 1, lat);
            for (int i = 0; i < n; i++) begin
                idx = cur.addr + memPkg::memAddr'(i);
                model[idx[memPkg::RamAddrBits-1:0]] = cur.wdata[i*8 +: 8];
            end
            cntStore++;
        end else begin
            if (!stalled) compare("load latency", n + 2, lat);
            compare("load rdata", modelWord(cur.addr, n), dataOut.rdata);
            cntLoad++;
        end
    endtask

    task automatic checkApb();
        regPkg::regData expected;
        logic mapped;
        mapped = 1'b1;
        case (apbIn.paddr)
            regPkg::OffCtrl:     expected = {30'd0, pause, fetchFirst};
            regPkg::OffFetchCnt: expected = regPkg::regData'(cntFetch);
            regPkg::OffLoadCnt:  expected = regPkg::regData'(cntLoad);
            regPkg::OffStoreCnt: expected = regPkg::regData'(cntStore);
            default: begin
                expected = '0;
                mapped = 1'b0;
            end
        endcase
        if (!apbOut.pready) fault("APB pready was low during an access");
        compare($sformatf("apb pslverr @%h", apbIn.paddr), {31'd0, !mapped}, apbOut.pslverr);
        if (!apbIn.pwrite || !mapped) begin
            compare($sformatf("apb prdata @%h", apbIn.paddr), expected, apbOut.prdata);
        end
    endtask

    task automatic updateRegs();
        if (apbIn.paddr == regPkg::OffCtrl) begin
            fetchFirst = apbIn.pwdata[0];
            pause = apbIn.pwdata[1];
        end else if (apbIn.paddr == regPkg::OffFetchCnt || apbIn.paddr == regPkg::OffLoadCnt
                || apbIn.paddr == regPkg::OffStoreCnt) begin
            // clear wins over an increment in the same cycle
            cntFetch = 0;
            cntLoad = 0;
            cntStore = 0;
        end
    endtask

    always @(posedge clk) begin : watch
        logic wasBusy;
        logic access;
        wasBusy = busy;
        access = apbIn.psel && apbIn.penable;
        if (rst) begin
            busy = 1'b0;
            fetchFirst = 1'b0;
            pause = 1'b0;
            cntFetch = 0;
            cntLoad = 0;
            cntStore = 0;
        end else begin
            if (access) checkApb();
            if (wasBusy) begin
                if (pause) stalled = 1'b1;
                else lat++;
            end
            if (fetchOut.done || dataOut.done) begin
                if (pause) fault("a done pulse appeared while the controller was paused");
                if (!wasBusy) begin
                    fault("a done pulse appeared with no transaction in flight");
                end else if (fetchOut.done && dataOut.done) begin
                    fault("both ports signalled done in the same cycle");
                end else if (fetchOut.done != curFetch) begin
                    fault("done came on the port that should have lost arbitration");
                end else begin
                    finishTxn();
                end
                busy = 1'b0;
            end else if (!wasBusy && !pause && (dataIn.valid || fetchIn.valid)) begin
                acceptReq();
            end
            if (access && apbIn.pwrite) updateRegs();
        end
    end

endmodule

// ==== tbMemSubsys.sv ====
`timescale 1ns/1ps

module tbMemSubsys;

    // window straddles the top of the RAM so accesses wrap
    localparam memPkg::memAddr WinBase = 16'h0F80;
    localparam int NumInit     = 65;
    localparam int NumRandom   = 60;
    localparam int NumExtra    = 11;
    localparam int PauseCycles = 24;
    localparam int CycleLimit  = (NumInit + NumRandom + NumExtra) * 12 + 2 * PauseCycles + 200;

    logic             clk = 1'b0;
    logic             rst;
    memPkg::fetchReq  fetchIn;
    memPkg::fetchResp fetchOut;
    memPkg::dataReq   dataIn;
    memPkg::dataResp  dataOut;
    regPkg::apbReq    apbIn;
    regPkg::apbResp   apbOut;
    int               errors;
    int               checks;
    int               cycles = 0;
    logic [15:0]      lfsr;

    always #4 clk = ~clk;

    memSubsys DUT (
        .clk      (clk),
        .rst      (rst),
        .fetchIn  (fetchIn),
        .fetchOut (fetchOut),
        .dataIn   (dataIn),
        .dataOut  (dataOut),
        .apbIn    (apbIn),
        .apbOut   (apbOut)
    );

    tbChecker uCheck (
        .clk      (clk),
        .rst      (rst),
        .fetchIn  (fetchIn),
        .fetchOut (fetchOut),
        .dataIn   (dataIn),
        .dataOut  (dataOut),
        .apbIn    (apbIn),
        .apbOut   (apbOut),
        .errors   (errors),
        .checks   (checks)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] takeBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic memPkg::xferLen pickLen(logic [1:0] r);
        case (r)
            2'd0:    return memPkg::LenByte;
            2'd1:    return memPkg::LenHalf;
            default: return memPkg::LenWord;
        endcase
    endfunction

    task automatic startData(logic w, memPkg::xferLen n, memPkg::memAddr a, memPkg::memWord d);
        @(posedge clk);
        dataIn <= '{valid: 1'b1, write: w, len: n, addr: a, wdata: d};
    endtask

    task automatic waitData();
        @(posedge clk);
        while (!dataOut.done) begin
            @(posedge clk);
        end
        dataIn.valid <= 1'b0;
    endtask

    task automatic dataAccess(logic w, memPkg::xferLen n, memPkg::memAddr a, memPkg::memWord d);
        startData(w, n, a, d);
        waitData();
    endtask

    task automatic startFetch(memPkg::memAddr a);
        @(posedge clk);
        fetchIn <= '{valid: 1'b1, addr: a};
    endtask

    task automatic waitFetch();
        @(posedge clk);
        while (!fetchOut.done) begin
            @(posedge clk);
        end
        fetchIn.valid <= 1'b0;
    endtask

    task automatic fetchAccess(memPkg::memAddr a);
        startFetch(a);
        waitFetch();
    endtask

    // load and fetch raised in the same idle cycle
    task automatic raceAccess(memPkg::memAddr loadAddr, memPkg::memAddr instAddr);
        logic gotData;
        logic gotFetch;
        gotData = 1'b0;
        gotFetch = 1'b0;
        @(posedge clk);
        dataIn <= '{valid: 1'b1, write: 1'b0, len: memPkg::LenWord, addr: loadAddr, wdata: '0};
        fetchIn <= '{valid: 1'b1, addr: instAddr};
        while (!(gotData && gotFetch)) begin
            @(posedge clk);
            if (dataOut.done) begin
                gotData = 1'b1;
                dataIn.valid <= 1'b0;
            end
            if (fetchOut.done) begin
                gotFetch = 1'b1;
                fetchIn.valid <= 1'b0;
            end
        end
    endtask

    task automatic apbAccess(logic w, regPkg::regAddr a, regPkg::regData d);
        @(posedge clk);
        apbIn <= '{psel: 1'b1, penable: 1'b0, pwrite: w, paddr: a, pwdata: d};
        @(posedge clk);
        apbIn.penable <= 1'b1;
        @(posedge clk);
        apbIn <= '0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("closing: %0d errors in %0d checks", errors, checks);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [1:0]     kind;
        memPkg::xferLen n;
        memPkg::memAddr a;
        memPkg::memWord d;
        lfsr = 16'd17818;
        rst = 1'b1;
        fetchIn = '0;
        dataIn = '0;
        apbIn = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // fill the window so every read has defined bytes
        for (int i = 0; i < NumInit; i++) begin
            d = takeBits(32);
            dataAccess(1'b1, memPkg::LenWord, WinBase + memPkg::memAddr'(4 * i), d);
        end

        for (int i = 0; i < NumRandom; i++) begin
            kind = 2'(takeBits(2));
            n = pickLen(2'(takeBits(2)));
            a = WinBase + memPkg::memAddr'(takeBits(8));
            d = takeBits(32);
            case (kind)
                2'd0:    fetchAccess(a);
                2'd3:    dataAccess(1'b1, n, a, d);
                default: dataAccess(1'b0, n, a, d);
            endcase
        end

        // across the 4095 to 0 boundary
        d = takeBits(32);
        dataAccess(1'b1, memPkg::LenWord, 16'h0FFE, d);
        dataAccess(1'b0, memPkg::LenWord, 16'h0FFE, '0);
        dataAccess(1'b0, memPkg::LenHalf, 16'h0FFF, '0);
        fetchAccess(16'h0FFD);

        raceAccess(WinBase + 16'h0010, WinBase + 16'h0040);
        apbAccess(1'b1, regPkg::OffCtrl, 32'h1);
        raceAccess(WinBase + 16'h0020, WinBase + 16'h0050);
        apbAccess(1'b0, regPkg::OffCtrl, '0);
        apbAccess(1'b1, regPkg::OffCtrl, 32'h0);

        // store and then fetch held off by pause
        a = WinBase + 16'h0030;
        d = takeBits(32);
        apbAccess(1'b1, regPkg::OffCtrl, 32'h2);
        startData(1'b1, memPkg::LenWord, a, d);
        repeat (PauseCycles) @(posedge clk);
        apbAccess(1'b1, regPkg::OffCtrl, 32'h0);
        waitData();
        dataAccess(1'b0, memPkg::LenWord, a, '0);
        apbAccess(1'b1, regPkg::OffCtrl, 32'h2);
        startFetch(a);
        repeat (PauseCycles) @(posedge clk);
        apbAccess(1'b1, regPkg::OffCtrl, 32'h0);
        waitFetch();

        apbAccess(1'b0, regPkg::OffFetchCnt, '0);
        apbAccess(1'b0, regPkg::OffLoadCnt, '0);
        apbAccess(1'b0, regPkg::OffStoreCnt, '0);
        apbAccess(1'b1, regPkg::OffStoreCnt, '0);
        apbAccess(1'b0, regPkg::OffFetchCnt, '0);
        apbAccess(1'b0, regPkg::OffLoadCnt, '0);
        apbAccess(1'b0, regPkg::OffStoreCnt, '0);

        // unmapped offset must not touch the control bits
        apbAccess(1'b1, regPkg::OffCtrl, 32'h1);
        apbAccess(1'b1, 8'h10, 32'h2);
        apbAccess(1'b0, 8'h10, '0);
        apbAccess(1'b0, regPkg::OffCtrl, '0);
        apbAccess(1'b1, regPkg::OffCtrl, 32'h0);
        repeat (4) @(posedge clk);

        $display("closing: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
memPkg.sv
regPkg.sv
byteRam.sv
memCtrl.sv
memRegs.sv
memSubsys.sv
tbChecker.sv
tbMemSubsys.sv

// ==== Bender.yml ====
package:
  name: memsubsys

sources:
  - memPkg.sv
  - regPkg.sv
  - byteRam.sv
  - memCtrl.sv
  - memRegs.sv
  - memSubsys.sv
  - target: simulation
    files:
      - tbChecker.sv
      - tbMemSubsys.sv
